// File: list.f
src/scope_pkg.sv
src/ctl_pkg.sv
src/pin_io.sv
src/clb.sv
src/osc.sv
src/gen.sv
src/acq_top.sv
tb/tb_clk.sv
tb/acq_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the acquisition core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module acq_tb -o acq_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/acq_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1

// File: src/acq_top.sv
// Top level connecting pin IO, calibration, oscilloscope and generator
`timescale 1ns/1ns

module acq_top import scope_pkg::*, ctl_pkg::*; #(
  parameter int unsigned OSC_LEN = 16,
  parameter int unsigned TBL_AW  = 6
) (
  input  logic              adc_clk,
  input  logic              top_rst,
  // Converter pins
  input  adc_raw_t          adc_dat_i,
  output dac_code_t         dac_dat_o,
  // Control
  input  cfg_t              cfg_i,
  input  evn_t              evn_i,
  // Generator table write
  input  logic              tbl_we_i,
  input  logic [TBL_AW-1:0] tbl_addr_i,
  input  gsmp_t             tbl_dat_i,
  // Capture stream
  output osc_str_t          osc_o,
  output logic              osc_irq_o
);

  // Acquire side
  smp_t  adc_smp;
  smp_t  osc_in;
  logic  osc_in_vld;
  // Generate side
  gsmp_t gen_smp;
  logic  gen_vld;
  gsmp_t dac_smp;
  logic  dac_vld;

  //////////////////////////////
  // Pins
  //////////////////////////////

  pin_io pin_io_inst (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .adc_smp_o (adc_smp),
    .dac_smp_i (dac_smp),
    .dac_vld_i (dac_vld),
    .dac_dat_o (dac_dat_o)
  );

  //////////////////////////////
  // Calibration
  //////////////////////////////

  clb clb_inst (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .cfg_i     (cfg_i.clb),
    .adc_smp_i (adc_smp),
    .gen_smp_i (gen_smp),
    .gen_vld_i (gen_vld),
    .osc_smp_o (osc_in),
    .osc_vld_o (osc_in_vld),
    .dac_smp_o (dac_smp),
    .dac_vld_o (dac_vld)
  );

  //////////////////////////////
  // Oscilloscope and generator
  //////////////////////////////

  osc #(
    .OSC_LEN (OSC_LEN)
  ) osc_inst (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .cfg_i     (cfg_i.osc),
    .evn_i     (evn_i),
    .sti_dat_i (osc_in),
    .sti_vld_i (osc_in_vld),
    .sto_o     (osc_o),
    .irq_o     (osc_irq_o)
  );

  gen #(
    .TBL_AW (TBL_AW)
  ) gen_inst (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .cfg_i      (cfg_i.gen),
    .evn_i      (evn_i),
    .tbl_we_i   (tbl_we_i),
    .tbl_addr_i (tbl_addr_i),
    .tbl_dat_i  (tbl_dat_i),
    .sto_dat_o  (gen_smp),
    .sto_vld_o  (gen_vld)
  );

endmodule : acq_top

// File: src/clb.sv
// Calibration pipelines for acquire and generate paths with saturation, loopback select
`timescale 1ns/1ns

module clb import scope_pkg::*, ctl_pkg::*; (
  input  logic     adc_clk,
  input  logic     top_rst,
  input  clb_cfg_t cfg_i,
  // Raw streams
  input  smp_t     adc_smp_i,
  input  gsmp_t    gen_smp_i,
  input  logic     gen_vld_i,
  // Calibrated streams
  output smp_t     osc_smp_o,
  output logic     osc_vld_o,
  output gsmp_t    dac_smp_o,
  output logic     dac_vld_o
);

  // Saturation bounds, widened to the sum width
  localparam logic signed [33:0] ACQ_HI = 34'sd32767;
  localparam logic signed [33:0] ACQ_LO = -34'sd32768;
  localparam logic signed [33:0] GEN_HI = 34'sd8191;
  localparam logic signed [33:0] GEN_LO = -34'sd8192;

  // Clamp a wide sum into [lo, hi]
  function automatic logic signed [33:0] sat(input logic signed [33:0] val,
                                             input logic signed [33:0] hi,
                                             input logic signed [33:0] lo);
    if (val > hi) begin
      return hi;
    end else if (val < lo) begin
      return lo;
    end
    return val;
  endfunction

  // Acquire input after loopback select
  smp_t acq_in;
  logic acq_in_vld;
  // Stage 1 products
  logic signed [32:0] acq_prod;
  logic signed [30:0] gen_prod;
  logic               acq_vld1;
  logic               gen_vld1;
  // Stage 2 sums before clamp
  logic signed [33:0] acq_sum;
  logic signed [33:0] gen_sum;

  // Loopback feeds the generator sample, sign extended
  always_comb begin
    if (cfg_i.loop) begin
      acq_in     = {{2{gen_smp_i[13]}}, gen_smp_i};
      acq_in_vld = gen_vld_i;
    end else begin
      acq_in     = adc_smp_i;
      acq_in_vld = 1'b1;
    end
  end

  //////////////////////////////
  // Stage 1, gain
  //////////////////////////////

  // Gain is unsigned, zero extended to keep it positive
  always_ff @(posedge adc_clk) begin
    acq_prod <= acq_in * $signed({1'b0, cfg_i.adc_gain});
    gen_prod <= gen_smp_i * $signed({1'b0, cfg_i.dac_gain});
  end

  //////////////////////////////
  // Stage 2, shift, offset, clamp
  //////////////////////////////

  // Shift by 14 removes the 0x4000 unity scale
  assign acq_sum = (acq_prod >>> 14) + $signed(cfg_i.adc_off);
  assign gen_sum = (gen_prod >>> 14) + $signed(cfg_i.dac_off);

  always_ff @(posedge adc_clk) begin
    osc_smp_o <= smp_t'(sat(acq_sum, ACQ_HI, ACQ_LO));
    dac_smp_o <= gsmp_t'(sat(gen_sum, GEN_HI, GEN_LO));
  end

  // Valids follow the data through both stages
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      acq_vld1  <= 1'b0;
      gen_vld1  <= 1'b0;
      osc_vld_o <= 1'b0;
      dac_vld_o <= 1'b0;
    end else begin
      acq_vld1  <= acq_in_vld;
      gen_vld1  <= gen_vld_i;
      osc_vld_o <= acq_vld1;
      dac_vld_o <= gen_vld1;
    end
  end

  // Overflow must land on a rail one cycle later
  a_acq_rail : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    (acq_sum > ACQ_HI || acq_sum < ACQ_LO) |=> (osc_smp_o == ACQ_HI || osc_smp_o == ACQ_LO)
  );

  a_gen_rail : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    (gen_sum > GEN_HI || gen_sum < GEN_LO) |=> (dac_smp_o == GEN_HI || dac_smp_o == GEN_LO)
  );

endmodule : clb

// File: src/ctl_pkg.sv
// Configuration and event structs, oscilloscope state and trigger source enums
package ctl_pkg;

  // Trigger source select
  typedef enum logic [0:0] {
    TRIG_SW       = 1'b0,
    TRIG_LVL_RISE = 1'b1
  } trig_src_t;

  // Oscilloscope FSM states
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    WAIT_TRIG = 2'd1,
    CAPTURE   = 2'd2
  } osc_state_t;

  // Calibration, gains use 0x4000 as unity
  typedef struct packed {
    logic        [15:0] adc_gain;
    logic signed [15:0] adc_off;
    logic        [15:0] dac_gain;
    logic signed [13:0] dac_off;
    logic               loop;
  } clb_cfg_t;

  // Oscilloscope, keeps one of every dec+1 samples
  typedef struct packed {
    logic        [15:0] dec;
    trig_src_t          trig_src;
    logic signed [15:0] trig_lvl;
  } osc_cfg_t;

  // Generator table address increment
  typedef struct packed {
    logic [7:0] step;
  } gen_cfg_t;

  typedef struct packed {
    clb_cfg_t clb;
    osc_cfg_t osc;
    gen_cfg_t gen;
  } cfg_t;

  // One-cycle strobes
  typedef struct packed {
    logic osc_arm;
    logic osc_trig;
    logic gen_start;
    logic gen_stop;
  } evn_t;

endpackage : ctl_pkg

// File: src/gen.sv
// Waveform generator with table memory, write port, start/stop control and address stepping
`timescale 1ns/1ns

module gen import scope_pkg::*, ctl_pkg::*; #(
  parameter int unsigned TBL_AW = 6
) (
  input  logic              adc_clk,
  input  logic              top_rst,
  input  gen_cfg_t          cfg_i,
  input  evn_t              evn_i,
  // Table write port
  input  logic              tbl_we_i,
  input  logic [TBL_AW-1:0] tbl_addr_i,
  input  gsmp_t             tbl_dat_i,
  // Output stream
  output gsmp_t             sto_dat_o,
  output logic              sto_vld_o
);

  localparam int unsigned TBL_DEPTH = 2 ** TBL_AW;

  // Waveform table
  gsmp_t tbl_mem [TBL_DEPTH];

  logic              running;
  logic [TBL_AW-1:0] rd_addr;

  //////////////////////////////
  // Control
  //////////////////////////////

  // Start restarts from entry 0
  // Address wraps naturally at TBL_AW bits
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      running   <= 1'b0;
      rd_addr   <= '0;
      sto_vld_o <= 1'b0;
    end else begin
      if (evn_i.gen_start) begin
        running <= 1'b1;
        rd_addr <= '0;
      end else if (evn_i.gen_stop) begin
        running <= 1'b0;
      end else if (running) begin
        rd_addr <= rd_addr + TBL_AW'(cfg_i.step);
      end
      // Valid lines up with the registered read
      sto_vld_o <= running;
    end
  end

  //////////////////////////////
  // Table
  //////////////////////////////

  // Registered read, one cycle latency
  always_ff @(posedge adc_clk) begin
    if (tbl_we_i) begin
      tbl_mem[tbl_addr_i] <= tbl_dat_i;
    end
    if (running) begin
      sto_dat_o <= tbl_mem[rd_addr];
    end
  end

  a_start_stop : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !(evn_i.gen_start && evn_i.gen_stop)
  );

endmodule : gen

// File: src/osc.sv
// Oscilloscope with decimation, trigger FSM, capture counter, stream output and interrupt
`timescale 1ns/1ns

module osc import scope_pkg::*, ctl_pkg::*; #(
  parameter int unsigned OSC_LEN = 16
) (
  input  logic     adc_clk,
  input  logic     top_rst,
  input  osc_cfg_t cfg_i,
  input  evn_t     evn_i,
  // Input stream
  input  smp_t     sti_dat_i,
  input  logic     sti_vld_i,
  // Output stream and completion pulse
  output osc_str_t sto_o,
  output logic     irq_o
);

  // Counter wide enough for OSC_LEN itself
  localparam int unsigned CW = $clog2(OSC_LEN + 1);

  osc_state_t    state;
  logic [15:0]   dec_cnt;
  logic [CW-1:0] cap_cnt;
  // Previous kept sample for edge detection
  smp_t          prev_dat;
  logic          prev_vld;
  // Per-cycle decisions
  logic          keep;
  logic          lvl_hit;
  logic          sw_hit;
  logic          cap;
  logic          cap_end;
  // Output registers
  smp_t          sto_dat;
  logic          sto_vld;
  logic          sto_last;

  always_comb begin
    // Sample survives decimation
    keep    = (state != IDLE) && sti_vld_i && (dec_cnt == '0);
    // Rising crossing, needs a previous kept sample
    lvl_hit = (cfg_i.trig_src == TRIG_LVL_RISE) && keep && prev_vld &&
              (prev_dat < cfg_i.trig_lvl) && (sti_dat_i >= cfg_i.trig_lvl);
    sw_hit  = (cfg_i.trig_src == TRIG_SW) && evn_i.osc_trig;
    // Arm wins over everything, the crossing sample is itself captured
    cap     = !evn_i.osc_arm && keep &&
              ((state == CAPTURE) || ((state == WAIT_TRIG) && lvl_hit));
    cap_end = cap && (cap_cnt == CW'(OSC_LEN - 1));
  end

  //////////////////////////////
  // Decimation and history
  //////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dec_cnt  <= '0;
      prev_vld <= 1'b0;
    end else if (evn_i.osc_arm) begin
      // Restart count, forget history
      dec_cnt  <= '0;
      prev_vld <= 1'b0;
    end else if ((state != IDLE) && sti_vld_i) begin
      dec_cnt  <= (dec_cnt >= cfg_i.dec) ? '0 : dec_cnt + 16'd1;
      if (keep) begin
        prev_vld <= 1'b1;
      end
    end
  end

  // History payload
  always_ff @(posedge adc_clk) begin
    if (keep) begin
      prev_dat <= sti_dat_i;
    end
  end

  //////////////////////////////
  // Trigger FSM and capture
  //////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      state   <= IDLE;
      cap_cnt <= '0;
    end else if (evn_i.osc_arm) begin
      state   <= WAIT_TRIG;
      cap_cnt <= '0;
    end else if (cap_end) begin
      state   <= IDLE;
      cap_cnt <= '0;
    end else begin
      if (cap) begin
        cap_cnt <= cap_cnt + CW'(1);
      end
      // SW trigger starts with the next kept sample
      if ((state == WAIT_TRIG) && (lvl_hit || sw_hit)) begin
        state <= CAPTURE;
      end
    end
  end

  // Stream output, one cycle behind the input
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sto_vld  <= 1'b0;
      sto_last <= 1'b0;
      irq_o    <= 1'b0;
    end else begin
      sto_vld  <= cap;
      sto_last <= cap_end;
      irq_o    <= cap_end;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (keep) begin
      sto_dat <= sti_dat_i;
    end
  end

  assign sto_o = '{dat: sto_dat, vld: sto_vld, last: sto_last};

  a_last_vld : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    sto_o.last |-> sto_o.vld
  );

  // Interrupt marks the end of the frame, no beat follows it
  a_irq_last : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    irq_o |-> sto_o.last ##1 !sto_o.vld
  );

endmodule : osc

// File: src/pin_io.sv
// ADC input register and DAC output register, both with negative-slope code conversion
`timescale 1ns/1ns

module pin_io import scope_pkg::*; (
  input  logic      adc_clk,
  input  logic      top_rst,
  // ADC side
  input  adc_raw_t  adc_dat_i,
  output smp_t      adc_smp_o,
  // DAC side
  input  gsmp_t     dac_smp_i,
  input  logic      dac_vld_i,
  output dac_code_t dac_dat_o
);

  //////////////////////////////
  // ADC input
  //////////////////////////////

  // IO register on the raw pins
  // MSB kept, rest inverted gives two's complement
  always_ff @(posedge adc_clk) begin
    adc_smp_o <= {adc_dat_i[15], ~adc_dat_i[14:0]};
  end

  //////////////////////////////
  // DAC output
  //////////////////////////////

  // 0x1FFF is mid scale in the DAC code
  // Held between valid samples
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= 14'h1FFF;
    end else if (dac_vld_i) begin
      // Signed to negative slope
      dac_dat_o <= {dac_smp_i[13], ~dac_smp_i[12:0]};
    end
  end

  // Pins must be driven to known levels once out of reset
  a_dac_known : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !$isunknown(dac_dat_o)
  );

endmodule : pin_io

// File: src/scope_pkg.sv
// Sample word types for ADC, DAC and generator, plus the oscilloscope stream struct
package scope_pkg;

  // Raw ADC word, negative-slope code from the converter
  typedef logic [15:0] adc_raw_t;

  // Acquire sample, two's complement
  typedef logic signed [15:0] smp_t;

  // Generate sample, two's complement
  typedef logic signed [13:0] gsmp_t;

  // DAC word, negative-slope code toward the converter
  typedef logic [13:0] dac_code_t;

  // Oscilloscope output stream
  // No ready here, the sink must take every beat
  typedef struct packed {
    smp_t dat;
    logic vld;
    logic last;
  } osc_str_t;

endpackage : scope_pkg

// File: tb/acq_tb.sv
// Testbench for the acquisition core: capture table, reference model, generator and DAC checks
`timescale 1ns/1ns

module acq_tb import scope_pkg::*, ctl_pkg::*; ();

  localparam int unsigned OSC_LEN = 16;
  localparam int unsigned TBL_AW  = 6;
  localparam int unsigned TBL_N   = 2 ** TBL_AW;
  // Run length and event cycles inside one capture run
  localparam int NCYC     = 160;
  localparam int ARM_C    = 10;
  localparam int TRIG_C   = 20;
  localparam int GEN_C    = 2;
  localparam int GEN_STEP = 5;

  // One capture scenario
  typedef struct packed {
    logic               sw;     // SW trigger, else rising level
    logic               loop;   // Generator looped into the scope
    logic               ramp;   // Ramp data, else random
    logic [15:0]        dec;
    logic signed [15:0] lvl;
    logic [15:0]        gain;
    logic signed [15:0] off;
    logic signed [15:0] start;  // Ramp start, sample domain
    logic signed [15:0] step;
  } cap_row_t;

  logic              adc_clk;
  logic              top_rst;
  adc_raw_t          adc_dat_i;
  cfg_t              cfg_i;
  evn_t              evn_i;
  logic              tbl_we_i;
  logic [TBL_AW-1:0] tbl_addr_i;
  gsmp_t             tbl_dat_i;
  osc_str_t          osc_o;
  logic              osc_irq_o;
  dac_code_t         dac_dat_o;

  integer   seed = 82;
  int       n_chk;
  int       n_err;
  cap_row_t cap_tbl [5];
  gsmp_t    tbl_ref [TBL_N];
  // Raw ADC word per run cycle, and scope input seen on each rising edge
  adc_raw_t raw [NCYC];
  smp_t     smp_at [NCYC];
  smp_t     exp_q [$];

  tb_clk #(
    .RST_CYC (8)
  ) tb_clk_inst (
    .clk_o (adc_clk),
    .rst_o (top_rst)
  );

  acq_top #(
    .OSC_LEN (OSC_LEN),
    .TBL_AW  (TBL_AW)
  ) acq_top_inst (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat_i),
    .dac_dat_o  (dac_dat_o),
    .cfg_i      (cfg_i),
    .evn_i      (evn_i),
    .tbl_we_i   (tbl_we_i),
    .tbl_addr_i (tbl_addr_i),
    .tbl_dat_i  (tbl_dat_i),
    .osc_o      (osc_o),
    .osc_irq_o  (osc_irq_o)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Negative slope code, MSB kept and the rest inverted
  function automatic smp_t adc_to_smp(input adc_raw_t code);
    return smp_t'(code ^ 16'h7FFF);
  endfunction

  function automatic dac_code_t smp_to_dac(input gsmp_t smp);
    return dac_code_t'(smp ^ 14'h1FFF);
  endfunction

  // Gain with 0x4000 as unity, floor shift, offset, clamp to [-hi-1, hi]
  function automatic longint scale(input longint x, input longint gain,
                                   input longint off, input longint hi);
    longint y;
    y = ((x * gain) >>> 14) + off;
    if (y > hi) begin
      y = hi;
    end else if (y < -hi - 1) begin
      y = -hi - 1;
    end
    return y;
  endfunction

  // DAC code for the k-th generator read after start
  function automatic dac_code_t dac_expect(input int k);
    longint v;
    v = scale(tbl_ref[(k * GEN_STEP) % TBL_N], cfg_i.clb.dac_gain, cfg_i.clb.dac_off, 8191);
    return smp_to_dac(gsmp_t'(v));
  endfunction

  // ADC words for a run and the scope input they become
  // 3 edges from ADC pins to scope input, generator lands 4 edges after start
  task automatic build_stream(input cap_row_t row);
    longint x;
    int     j;
    for (int p = 0; p < NCYC; p++) begin
      if (row.ramp) begin
        raw[p] = adc_raw_t'(smp_t'(row.start + p * row.step)) ^ 16'h7FFF;
      end else begin
        raw[p] = adc_raw_t'($random(seed));
      end
    end
    for (int p = 0; p < NCYC; p++) begin
      j = p - GEN_C - 4;
      if (row.loop) begin
        x = (j < 0) ? 0 : tbl_ref[(j * GEN_STEP) % TBL_N];
      end else begin
        x = (p < 3) ? 0 : adc_to_smp(raw[p - 3]);
      end
      smp_at[p] = smp_t'(scale(x, row.gain, row.off, 32767));
    end
  endtask

  // Expected frame from the kept samples and the trigger rules
  task automatic model_capture(input cap_row_t row);
    bit   capturing;
    bit   have_prev;
    smp_t prev;
    smp_t v;
    exp_q.delete();
    capturing = 1'b0;
    have_prev = 1'b0;
    prev      = '0;
    for (int p = ARM_C + 1; p < NCYC; p++) begin
      if ((p - ARM_C - 1) % (int'(row.dec) + 1) == 0 && exp_q.size() < OSC_LEN) begin
        v = smp_at[p];
        // Crossing sample is part of the frame
        if (!capturing && !row.sw && have_prev && prev < row.lvl && v >= row.lvl) begin
          capturing = 1'b1;
        end
        if (capturing) begin
          exp_q.push_back(v);
        end
        prev      = v;
        have_prev = 1'b1;
      end
      // SW trigger takes effect from the next kept sample
      if (row.sw && p == TRIG_C) begin
        capturing = 1'b1;
      end
    end
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic compare_val(input string name, input longint got, input longint exp);
    n_chk++;
    if (got != exp) begin
      n_err++;
      $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // One cycle of the capture stream
  task automatic observe_osc(inout int n_beat, inout int n_irq);
    bit fin;
    fin = osc_o.vld && (n_beat == OSC_LEN - 1);
    if (osc_o.vld) begin
      if (n_beat < exp_q.size()) begin
        compare_val("osc_o.dat", osc_o.dat, exp_q[n_beat]);
      end
      compare_val("osc_o.last", osc_o.last, fin);
      n_beat++;
    end
    compare_val("osc_irq_o", osc_irq_o, fin);
    if (osc_irq_o) begin
      n_irq++;
    end
  endtask

  task automatic reset_check();
    int cyc;
    cyc = 0;
    @(negedge adc_clk);
    while (top_rst && cyc < 40) begin
      compare_val("dac_dat_o", dac_dat_o, 14'h1FFF);
      @(negedge adc_clk);
      cyc++;
    end
    if (top_rst) begin
      n_err++;
      $display("Reset was never released");
    end
    repeat (4) begin
      @(negedge adc_clk);
      compare_val("dac_dat_o", dac_dat_o, 14'h1FFF);
      compare_val("osc_o.vld", osc_o.vld, 0);
      compare_val("osc_irq_o", osc_irq_o, 0);
    end
  endtask

  //////////////////////////////
  // Scenarios
  //////////////////////////////

  // Cycle c drives the inputs taken on rising edge c
  task automatic run_capture(input int idx, input cap_row_t row);
    int n_beat;
    int n_irq;
    int c;
    build_stream(row);
    model_capture(row);
    n_beat = 0;
    n_irq  = 0;
    @(negedge adc_clk);
    cfg_i.clb.adc_gain = row.gain;
    cfg_i.clb.adc_off  = row.off;
    cfg_i.clb.loop     = row.loop;
    cfg_i.osc.dec      = row.dec;
    cfg_i.osc.trig_lvl = row.lvl;
    cfg_i.osc.trig_src = row.sw ? TRIG_SW : TRIG_LVL_RISE;
    c = 0;
    while (c < NCYC && n_irq == 0) begin
      @(negedge adc_clk);
      observe_osc(n_beat, n_irq);
      adc_dat_i       = raw[c];
      evn_i           = '0;
      evn_i.osc_arm   = (c == ARM_C);
      evn_i.osc_trig  = row.sw && (c == TRIG_C);
      evn_i.gen_start = row.loop && (c == GEN_C);
      c++;
    end
    if (n_irq == 0) begin
      n_err++;
      $display("Capture row %0d did not complete within %0d cycles", idx, NCYC);
    end
    // Stream must stay quiet after the frame
    repeat (4) begin
      @(negedge adc_clk);
      observe_osc(n_beat, n_irq);
      evn_i = '0;
    end
    compare_val("capture beats", n_beat, OSC_LEN);
    compare_val("irq pulses", n_irq, 1);
    if (row.loop) begin
      evn_i.gen_stop = 1'b1;
      @(negedge adc_clk);
      evn_i          = '0;
      cfg_i.clb.loop = 1'b0;
    end
  endtask

  task automatic gen_dac_test();
    int cyc;
    for (int a = 0; a < TBL_N; a++) begin
      @(negedge adc_clk);
      tbl_we_i   = 1'b1;
      tbl_addr_i = TBL_AW'(a);
      tbl_dat_i  = tbl_ref[a];
    end
    @(negedge adc_clk);
    tbl_we_i        = 1'b0;
    evn_i.gen_start = 1'b1;
    @(negedge adc_clk);
    evn_i = '0;
    // First new code 4 edges after the start edge
    cyc = 0;
    while (dac_dat_o == 14'h1FFF && cyc < 20) begin
      @(negedge adc_clk);
      cyc++;
    end
    if (cyc == 20) begin
      n_err++;
      $display("DAC output never left its reset value after gen_start");
    end else begin
      compare_val("dac latency", cyc, 4);
    end
    for (int k = 0; k < 40; k++) begin
      compare_val("dac_dat_o", dac_dat_o, dac_expect(k));
      @(negedge adc_clk);
    end
    // Stop edge still reads entry 44
    evn_i.gen_stop = 1'b1;
    @(negedge adc_clk);
    evn_i = '0;
    repeat (6) @(negedge adc_clk);
    repeat (10) begin
      @(negedge adc_clk);
      compare_val("dac_dat_o held", dac_dat_o, dac_expect(44));
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    n_chk      = 0;
    n_err      = 0;
    adc_dat_i  = '0;
    evn_i      = '0;
    tbl_we_i   = 1'b0;
    tbl_addr_i = '0;
    tbl_dat_i  = '0;
    cfg_i                = '0;
    cfg_i.clb.adc_gain   = 16'h4000;
    cfg_i.clb.dac_gain   = 16'h6000;
    cfg_i.clb.dac_off    = 14'sd100;
    cfg_i.osc.trig_src   = TRIG_SW;
    cfg_i.gen.step       = 8'(GEN_STEP);
    // Linear fill, -8000 up to full scale
    for (int a = 0; a < TBL_N; a++) begin
      tbl_ref[a] = gsmp_t'(a * 257 - 8000);
    end
    cap_tbl[0] = '{sw: 1'b1, loop: 1'b0, ramp: 1'b0, dec: 16'd0, lvl: 16'sd0,
                   gain: 16'h4000, off: 16'sd0, start: 16'sd0, step: 16'sd0};
    cap_tbl[1] = '{sw: 1'b0, loop: 1'b0, ramp: 1'b1, dec: 16'd2, lvl: 16'sd100,
                   gain: 16'h4000, off: 16'sd0, start: -16'sd500, step: 16'sd7};
    // Gain of 2 and offset, random data hits both rails
    cap_tbl[2] = '{sw: 1'b1, loop: 1'b0, ramp: 1'b0, dec: 16'd0, lvl: 16'sd0,
                   gain: 16'h8000, off: 16'sd1000, start: 16'sd0, step: 16'sd0};
    // Ramp runs into the upper rail during the frame
    cap_tbl[3] = '{sw: 1'b0, loop: 1'b0, ramp: 1'b1, dec: 16'd1, lvl: -16'sd10000,
                   gain: 16'h6000, off: -16'sd3000, start: -16'sd30000, step: 16'sd1000};
    cap_tbl[4] = '{sw: 1'b1, loop: 1'b1, ramp: 1'b0, dec: 16'd0, lvl: 16'sd0,
                   gain: 16'h5000, off: -16'sd50, start: 16'sd0, step: 16'sd0};

    reset_check();
    for (int i = 0; i < 4; i++) begin
      run_capture(i, cap_tbl[i]);
    end
    gen_dac_test();
    // Loopback needs the table loaded
    run_capture(4, cap_tbl[4]);

    $display("Checks: %0d, errors: %0d", n_chk, n_err);
    if (n_err == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : acq_tb

// File: tb/tb_clk.sv
// Testbench clock and reset source
`timescale 1ns/1ns

module tb_clk #(
  parameter int unsigned RST_CYC = 8
) (
  output logic clk_o,
  output logic rst_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Released on a falling edge, away from the sampling edge
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYC) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule : tb_clk
